// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_twoway_cache -f twoway_cache.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== source/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    // cpu side, wishbone slave
    input  logic       cpu_cyc_i,
    input  logic       cpu_stb_i,
    input  logic       cpu_we_i,
    input  addr_t      cpu_adr_i,
    input  data_t      cpu_dat_i,
    output data_t      cpu_dat_o,
    output logic       cpu_ack_o,

    // memory side, wishbone master
    output logic       mem_cyc_o,
    output logic       mem_stb_o,
    output logic       mem_we_o,
    output addr_t      mem_adr_o,
    output data_t      mem_dat_o,
    input  data_t      mem_dat_i,
    input  logic       mem_ack_i,

    // store interface
    output cache_req_t req_o,
    input  lookup_t    lookup_i,
    output logic       tag_fill_o,
    output way_t       fill_way_o,
    output logic       touch_o,
    output way_t       touch_way_o,
    output logic       data_we_o,
    output way_t       data_way_o,
    output way_t       rd_way_o,
    output data_t      wdata_o,
    input  data_t      rdata_i
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    cache_req_t  req_q;
    data_t       resp_q;

    logic start;

    assign start = cpu_cyc_i && cpu_stb_i;

    // ####################
    // state register
    // ####################
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = LOOKUP;
            LOOKUP: begin
                if (req_q.we) begin
                    state_d = MEM_WR;        // write-through, hit or miss
                end else if (lookup_i.hit) begin
                    state_d = RESP;
                end else begin
                    state_d = MEM_RD;
                end
            end
            MEM_RD:  if (mem_ack_i) state_d = RESP;
            MEM_WR:  if (mem_ack_i) state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // request and response word, payload only
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start) begin
            req_q.set   <= cpu_adr_i[SET_WIDTH+1:2];
            req_q.tag   <= cpu_adr_i[ADDR_WIDTH-1:ADDR_WIDTH-TAG_WIDTH];
            req_q.wdata <= cpu_dat_i;
            req_q.we    <= cpu_we_i;
        end
        if (state_q == LOOKUP && !req_q.we) begin
            resp_q <= rdata_i;                // hit word, overwritten on a miss
        end else if (state_q == MEM_RD && mem_ack_i) begin
            resp_q <= mem_dat_i;
        end
    end

    // ####################
    // store strobes
    // ####################
    always_comb begin
        tag_fill_o  = 1'b0;
        fill_way_o  = lookup_i.victim;
        touch_o     = 1'b0;
        touch_way_o = lookup_i.hit_way;
        data_we_o   = 1'b0;
        data_way_o  = lookup_i.hit_way;
        wdata_o     = req_q.wdata;
        case (state_q)
            LOOKUP: begin
                // read hit only moves round-robin
                touch_o = !req_q.we && lookup_i.hit;
            end
            MEM_RD: begin
                tag_fill_o = mem_ack_i;
                data_we_o  = mem_ack_i;
                data_way_o = lookup_i.victim;
                wdata_o    = mem_dat_i;
            end
            MEM_WR: begin
                touch_o   = mem_ack_i && lookup_i.hit; // a write miss allocates nothing
                data_we_o = mem_ack_i && lookup_i.hit;
            end
            default: ;
        endcase
    end

    assign rd_way_o = lookup_i.hit_way;
    assign req_o    = req_q;

    // ####################
    // bus outputs
    // ####################
    assign cpu_ack_o = (state_q == RESP);
    assign cpu_dat_o = resp_q;

    assign mem_cyc_o = (state_q == MEM_RD) || (state_q == MEM_WR);
    assign mem_stb_o = mem_cyc_o;
    assign mem_we_o  = (state_q == MEM_WR);
    assign mem_adr_o = {req_q.tag, req_q.set, 2'b00}; // word aligned
    assign mem_dat_o = req_q.wdata;

endmodule : cache_ctrl

`default_nettype wire

// ==== source/cache_data_store.sv ====
`default_nettype none

module cache_data_store
    import cache_pkg::*;
(
    input  logic     clk_i,
    input  set_idx_t set_i,
    input  way_t     rd_way_i,
    input  logic     data_we_i,
    input  way_t     data_way_i,
    input  data_t    wdata_i,
    output data_t    rdata_o
);

    data_t words_q [NUM_SETS][2]; // one word per line

    // combinational read of the selected way
    assign rdata_o = words_q[set_i][rd_way_i];

    always_ff @(posedge clk_i) begin
        if (data_we_i) begin
            words_q[set_i][data_way_i] <= wdata_i;
        end
    end

endmodule : cache_data_store

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // ####################
    // widths
    // ####################
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_SETS   = 8;
    localparam int SET_WIDTH  = 3;  // address bits 4:2
    localparam int TAG_WIDTH  = 27; // address bits 31:5

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [SET_WIDTH-1:0]  set_idx_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic                  way_t;

    // ####################
    // structs
    // ####################

    // one cpu request, held for the whole transaction
    typedef struct packed {
        set_idx_t set;
        tag_t     tag;
        data_t    wdata;
        logic     we;
    } cache_req_t;

    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim; // next way to be replaced in this set
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_RD,
        MEM_WR,
        RESP
    } ctrl_state_t;

endpackage : cache_pkg

`default_nettype wire

// ==== source/cache_tag_store.sv ====
`default_nettype none

module cache_tag_store
    import cache_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  cache_req_t req_i,
    input  logic       tag_fill_i,
    input  way_t       fill_way_i,
    input  logic       touch_i,
    input  way_t       touch_way_i,
    output lookup_t    lookup_o
);

    logic [NUM_SETS-1:0][1:0] valid_q;
    logic [NUM_SETS-1:0]      rr_q;    // way to replace next, per set
    tag_t                     tags_q [NUM_SETS][2];

    logic hit0;
    logic hit1;

    // ####################
    // lookup
    // ####################
    assign hit0 = valid_q[req_i.set][0] && (tags_q[req_i.set][0] == req_i.tag);
    assign hit1 = valid_q[req_i.set][1] && (tags_q[req_i.set][1] == req_i.tag);

    always_comb begin
        lookup_o.hit     = hit0 || hit1;
        lookup_o.hit_way = hit1;             // way 0 unless way 1 matched
        lookup_o.victim  = rr_q[req_i.set];
    end

    // ####################
    // update
    // ####################
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else begin
            if (tag_fill_i) begin
                valid_q[req_i.set][fill_way_i] <= 1'b1;
                rr_q[req_i.set]                <= ~fill_way_i; // other way goes next
            end else if (touch_i) begin
                rr_q[req_i.set] <= ~touch_way_i;
            end
        end
    end

    // tags only matter once the valid bit is set
    always_ff @(posedge clk_i) begin
        if (tag_fill_i) begin
            tags_q[req_i.set][fill_way_i] <= req_i.tag;
        end
    end

endmodule : cache_tag_store

`default_nettype wire

// ==== source/twoway_cache_top.sv ====
`default_nettype none

module twoway_cache_top
    import cache_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,

    input  logic  cpu_cyc_i,
    input  logic  cpu_stb_i,
    input  logic  cpu_we_i,
    input  addr_t cpu_adr_i,
    input  data_t cpu_dat_i,
    output data_t cpu_dat_o,
    output logic  cpu_ack_o,

    output logic  mem_cyc_o,
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output addr_t mem_adr_o,
    output data_t mem_dat_o,
    input  data_t mem_dat_i,
    input  logic  mem_ack_i
);

    cache_req_t req;
    lookup_t    lookup;
    logic       tag_fill;
    logic       touch;
    logic       data_we;
    way_t       fill_way;
    way_t       touch_way;
    way_t       data_way;
    way_t       rd_way;
    data_t      wdata;
    data_t      rdata;

    cache_ctrl ctrl0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cpu_cyc_i   (cpu_cyc_i),
        .cpu_stb_i   (cpu_stb_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_adr_i   (cpu_adr_i),
        .cpu_dat_i   (cpu_dat_i),
        .cpu_dat_o   (cpu_dat_o),
        .cpu_ack_o   (cpu_ack_o),
        .mem_cyc_o   (mem_cyc_o),
        .mem_stb_o   (mem_stb_o),
        .mem_we_o    (mem_we_o),
        .mem_adr_o   (mem_adr_o),
        .mem_dat_o   (mem_dat_o),
        .mem_dat_i   (mem_dat_i),
        .mem_ack_i   (mem_ack_i),
        .req_o       (req),
        .lookup_i    (lookup),
        .tag_fill_o  (tag_fill),
        .fill_way_o  (fill_way),
        .touch_o     (touch),
        .touch_way_o (touch_way),
        .data_we_o   (data_we),
        .data_way_o  (data_way),
        .rd_way_o    (rd_way),
        .wdata_o     (wdata),
        .rdata_i     (rdata)
    );

    cache_tag_store tags0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .tag_fill_i  (tag_fill),
        .fill_way_i  (fill_way),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .lookup_o    (lookup)
    );

    cache_data_store data0 (
        .clk_i      (clk_i),
        .set_i      (req.set),
        .rd_way_i   (rd_way),
        .data_we_i  (data_we),
        .data_way_i (data_way),
        .wdata_i    (wdata),
        .rdata_o    (rdata)
    );

endmodule : twoway_cache_top

`default_nettype wire

// ==== twoway_cache.f ====
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_ctrl.sv
source/twoway_cache_top.sv
verif/wb_mem_model.sv
verif/tb_twoway_cache.sv

// ==== verif/tb_twoway_cache.sv ====
`default_nettype none

module tb_twoway_cache
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ACCESSES = 320;
    localparam int WATCHDOG_NS  = NUM_ACCESSES * 10 * 40 + 20 * 40;

    typedef struct packed {
        data_t       data;
        logic        is_read;
        logic [31:0] mem_cnt; // memory cycles done once this ack arrives
    } expect_t;

    typedef struct packed {
        logic  we;
        addr_t adr;
        data_t dat;
    } mem_bus_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    addr_t       cpu_adr;
    data_t       cpu_wdat;
    data_t       cpu_rdat;
    logic        cpu_ack;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    addr_t       mem_adr;
    data_t       mem_wdat;
    data_t       mem_rdat;
    logic        mem_ack;
    logic [31:0] mem_cycles;

    // ####################
    // reference model
    // ####################
    logic [1:0]  m_valid [NUM_SETS];
    tag_t        m_tag   [NUM_SETS][2];
    data_t       m_data  [NUM_SETS][2];
    way_t        m_rr    [NUM_SETS];
    data_t       m_mem   [addr_t];
    logic [31:0] m_cnt = '0;

    expect_t exp_q [$];
    string   cur_test;
    int      cmp_errs  = 0;  // counted by the compare process
    int      seq_errs  = 0;  // counted by the test sequence
    int      check_cnt = 0;
    int      test_cnt  = 0;
    int      test_fails = 0;
    int      test_err0 = 0;

    mem_bus_t bus_q;
    logic     bus_wait = 1'b0; // memory cycle open and not acked at the last edge
    logic     bus_done = 1'b0; // memory ack seen at the last edge

    always #20 clk = ~clk;

    twoway_cache_top dut0 (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .cpu_cyc_i (cpu_cyc),
        .cpu_stb_i (cpu_stb),
        .cpu_we_i  (cpu_we),
        .cpu_adr_i (cpu_adr),
        .cpu_dat_i (cpu_wdat),
        .cpu_dat_o (cpu_rdat),
        .cpu_ack_o (cpu_ack),
        .mem_cyc_o (mem_cyc),
        .mem_stb_o (mem_stb),
        .mem_we_o  (mem_we),
        .mem_adr_o (mem_adr),
        .mem_dat_o (mem_wdat),
        .mem_dat_i (mem_rdat),
        .mem_ack_i (mem_ack)
    );

    wb_mem_model mem0 (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .cyc_i    (mem_cyc),
        .stb_i    (mem_stb),
        .we_i     (mem_we),
        .adr_i    (mem_adr),
        .dat_i    (mem_wdat),
        .dat_o    (mem_rdat),
        .ack_o    (mem_ack),
        .cycles_o (mem_cycles)
    );

    function automatic data_t mem_word(addr_t wa);
        if (m_mem.exists(wa)) begin
            return m_mem[wa];
        end
        return ~wa ^ 32'h5a5a0000;
    endfunction

    // one access on the model, returns what the DUT should answer
    function automatic expect_t model_access(addr_t a, logic we, data_t wd);
        set_idx_t s;
        tag_t     t;
        addr_t    wa;
        logic     hit;
        way_t     w;
        expect_t  e;
        s   = a[4:2];
        t   = a[31:5];
        wa  = {a[31:2], 2'b00};
        hit = 1'b0;
        w   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        e.is_read = !we;
        e.data    = wd;
        if (we) begin
            m_mem[wa] = wd;
            m_cnt++;
            if (hit) begin
                m_data[s][w] = wd;
                m_rr[s]      = ~w;
            end
        end else begin
            if (!hit) begin
                w             = m_rr[s]; // fill the victim
                m_data[s][w]  = mem_word(wa);
                m_tag[s][w]   = t;
                m_valid[s][w] = 1'b1;
                m_cnt++;
            end
            m_rr[s] = ~w;
            e.data  = m_data[s][w];
        end
        e.mem_cnt = m_cnt;
        return e;
    endfunction

    // ####################
    // driver and checks
    // ####################
    task automatic cpu_access(input addr_t a, input logic we, input data_t wd,
                              output int lat);
        int n;
        exp_q.push_back(model_access(a, we, wd));
        @(posedge clk);
        cpu_cyc  <= 1'b1;
        cpu_stb  <= 1'b1;
        cpu_we   <= we;
        cpu_adr  <= a;
        cpu_wdat <= wd;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cpu_ack);
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        lat = n - 1; // edges from the sampling edge to ack
    endtask

    task automatic check_latency(input int lat);
        assert (lat == 2) else begin
            $display("mismatch %s hit latency expected 2 actual %0d", cur_test, lat);
            seq_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = cmp_errs + seq_errs;
    endtask

    task automatic end_test();
        int errs;
        @(negedge clk); // let the compare process see the last ack
        errs = cmp_errs + seq_errs - test_err0;
        test_cnt++;
        if (errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            test_fails++;
            $display("test %s: %0d errors", cur_test, errs);
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        if (arst_n && cpu_ack) begin
            assert (exp_q.size() != 0) else begin
                $display("error in %s: the DUT acked with no request outstanding", cur_test);
                cmp_errs++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_cnt++;
                if (e.is_read) begin
                    assert (cpu_rdat == e.data) else begin
                        $display("mismatch %s read data expected %h actual %h",
                                 cur_test, e.data, cpu_rdat);
                        cmp_errs++;
                    end
                end
                assert (mem_cycles == e.mem_cnt) else begin
                    $display("mismatch %s memory cycles expected %0d actual %0d",
                             cur_test, e.mem_cnt, mem_cycles);
                    cmp_errs++;
                end
            end
        end
    end

    // memory master rules: stb with cyc, request held until ack, cycle closed after ack
    always @(posedge clk) begin
        if (arst_n) begin
            assert (mem_stb == mem_cyc) else begin
                $display("error in %s: memory stb and cyc differ", cur_test);
                cmp_errs++;
            end
            if (bus_wait) begin
                assert (mem_cyc && {mem_we, mem_adr, mem_wdat} == bus_q) else begin
                    $display("error in %s: memory request changed before ack", cur_test);
                    cmp_errs++;
                end
            end
            if (bus_done) begin
                assert (!mem_cyc) else begin
                    $display("error in %s: memory cycle still open after ack", cur_test);
                    cmp_errs++;
                end
            end
            bus_wait <= mem_cyc && !mem_ack;
            bus_done <= mem_cyc && mem_ack;
            bus_q    <= {mem_we, mem_adr, mem_wdat};
        end
    end

    // ####################
    // tests
    // ####################
    initial begin
        int   lat;
        int   idx;
        logic we;
        void'($urandom(32'h326c));
        arst_n   = 1'b0;
        cpu_cyc  = 1'b0;
        cpu_stb  = 1'b0;
        cpu_we   = 1'b0;
        cpu_adr  = '0;
        cpu_wdat = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = 2'b00;
            m_rr[s]    = 1'b0;
        end
        repeat (10) @(posedge clk);
        begin_test("reset");
        assert (!cpu_ack && !mem_cyc && !mem_stb) else begin
            $display("error in %s: ack or memory cycle active during reset", cur_test);
            seq_errs++;
        end
        arst_n <= 1'b1;
        end_test();
        @(posedge clk);

        begin_test("cold_reads");
        for (int i = 0; i < 4; i++) begin
            cpu_access(32'h100 + 32'(i) * 32'h104, 1'b0, '0, lat); // sets 0 to 3
        end
        end_test();

        begin_test("hit_latency");
        cpu_access(32'h100, 1'b0, '0, lat);
        check_latency(lat);
        cpu_access(32'h204, 1'b0, '0, lat);
        check_latency(lat);
        end_test();

        begin_test("write_through");
        cpu_access(32'h204, 1'b1, 32'hcafe_0204, lat);  // hit
        cpu_access(32'h204, 1'b0, '0, lat);
        cpu_access(32'h5010, 1'b1, 32'h1234_5010, lat); // miss, no allocate
        cpu_access(32'h5010, 1'b0, '0, lat);
        end_test();

        // A, B, C all in set 7
        begin_test("replacement");
        cpu_access(32'h001c, 1'b0, '0, lat);
        cpu_access(32'h101c, 1'b0, '0, lat);
        cpu_access(32'h201c, 1'b0, '0, lat);
        cpu_access(32'h101c, 1'b0, '0, lat);
        cpu_access(32'h001c, 1'b0, '0, lat);
        end_test();

        begin_test("random");
        for (int i = 0; i < 300; i++) begin
            idx = int'($urandom % 64);
            we  = 1'($urandom % 2);
            cpu_access(32'h8000 + 32'(idx) * 32'd4, we, $urandom, lat);
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fails, check_cnt, cmp_errs + seq_errs);
        if (cmp_errs + seq_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule : tb_twoway_cache

`default_nettype wire

// ==== verif/wb_mem_model.sv ====
`default_nettype none

module wb_mem_model
    import cache_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  addr_t       adr_i,
    input  data_t       dat_i,
    output data_t       dat_o,
    output logic        ack_o,
    output logic [31:0] cycles_o  // completed bus cycles
);
    timeunit 1ns;
    timeprecision 1ps;

    data_t mem [addr_t]; // sparse, untouched words come from the fill formula
    int    wait_q;

    function automatic data_t word_at(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o    <= 1'b0;
            dat_o    <= '0;
            wait_q   <= 0;
            cycles_o <= '0;
        end else if (ack_o) begin
            ack_o  <= 1'b0;
            wait_q <= int'($urandom % 4); // extra wait for the next cycle
        end else if (cyc_i && stb_i) begin
            if (wait_q != 0) begin
                wait_q <= wait_q - 1;
            end else begin
                ack_o    <= 1'b1;
                cycles_o <= cycles_o + 1;
                if (we_i) begin
                    mem[adr_i] = dat_i;
                end else begin
                    dat_o <= word_at(adr_i);
                end
            end
        end
    end

endmodule : wb_mem_model

`default_nettype wire
